/* tb.f */
common/topo_pkg.sv
src/indegree_table.sv
adjacency_map/adjacency_map.sv
sorter/kahn_sorter.sv
src/graph_topo_top.sv
bench/graph_topo_tb.sv

/* Makefile */
TOP = graph_topo_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim
	./obj_dir/sim 2>&1 | tee run.log
	@if grep -q "TESTBENCH FAILED" run.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" run.log || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

/* bench/graph_topo_tb.sv */
`timescale 1ns/1ps

module graph_topo_tb import topo_pkg::*; ();

    localparam int num_tests  = 27;
    localparam int num_random = 20;
    localparam int pool_size  = 512;

    logic        clk;
    logic        arst_n;
    logic        edge_stb;
    graph_edge_t edge_in;
    logic        load_done;
    cnt_t        node_count;
    logic        sort_stb;
    sorted_t     sort_out;
    logic        done;
    logic        cycle_found;

    // Graph table. Edges and exact orders sit in shared pools indexed per test.
    string       t_name    [num_tests];
    int          t_nodes   [num_tests];
    int          t_cycle   [num_tests];
    int          t_count   [num_tests];  // Nodes expected out before done.
    int          t_e_first [num_tests];
    int          t_e_num   [num_tests];
    int          t_o_first [num_tests];  // Negative when any valid order is accepted.
    graph_edge_t edge_pool [pool_size];
    int          order_pool[pool_size];
    int          n_built;
    int          edge_fill;
    int          order_fill;

    string cur_name;
    int    errors;
    int    test_errors;
    int    tests_failed;
    int    cycles;
    int    cycle_limit;
    int    got[$];
    int    last_idx;
    int    cyc_flag;

    graph_topo_top graph_topo_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .edge_stb    (edge_stb),
        .edge_in     (edge_in),
        .load_done   (load_done),
        .node_count  (node_count),
        .sort_stb    (sort_stb),
        .sort_out    (sort_out),
        .done        (done),
        .cycle_found (cycle_found)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycle_limit > 0 && cycles > cycle_limit) begin
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("TESTBENCH FAILED");
                $finish;
            end
        end
    end

    task automatic check(input string what, input int expected, input int actual);
        if (expected !== actual) begin
            $display("** Error: %s: %s expected %0d actual %0d",
                     cur_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic new_entry(input string name, input int nodes, input int cyc, input int count);
        t_name[n_built]    = name;
        t_nodes[n_built]   = nodes;
        t_cycle[n_built]   = cyc;
        t_count[n_built]   = count;
        t_e_first[n_built] = edge_fill;
        t_e_num[n_built]   = 0;
        t_o_first[n_built] = -1;
        n_built++;
    endtask

    task automatic append_edge(input int s, input int d);
        edge_pool[edge_fill].src = node_t'(s);
        edge_pool[edge_fill].dst = node_t'(d);
        edge_fill++;
        t_e_num[n_built-1]++;
    endtask

    task automatic append_order(input int v);
        if (t_o_first[n_built-1] < 0) begin
            t_o_first[n_built-1] = order_fill;
        end
        order_pool[order_fill] = v;
        order_fill++;
    endtask

    task automatic build_table();
        int v;
        int r;
        int k;
        int n;
        int e;
        int s;
        // Chain 0..7 loaded out of order. Only one order is valid.
        new_entry("chain", 8, 0, 8);
        append_edge(3, 4);
        append_edge(0, 1);
        append_edge(6, 7);
        append_edge(2, 3);
        append_edge(5, 6);
        append_edge(1, 2);
        append_edge(4, 5);
        for (v = 0; v < 8; v++) append_order(v);
        new_entry("no_edges", 5, 0, 5);
        for (v = 0; v < 5; v++) append_order(v);
        new_entry("hand_dag", 8, 0, 8);
        append_edge(0, 2);
        append_edge(1, 2);
        append_edge(2, 5);
        append_edge(0, 3);
        append_edge(3, 5);
        append_edge(4, 6);
        append_edge(5, 7);
        append_edge(6, 7);
        append_edge(1, 4);
        // Edges always run upward in index, so every random graph is acyclic.
        for (r = 0; r < num_random; r++) begin
            n = 2 + int'($urandom % 15);
            e = int'($urandom % 17);
            new_entry($sformatf("random_%0d", r), n, 0, n);
            for (k = 0; k < e; k++) begin
                s = int'($urandom % (n - 1));
                append_edge(s, s + 1 + int'($urandom % (n - 1 - s)));
            end
        end
        // Cycle 2->3->4->2. Nodes 2..5 hang off it, so only 0, 1 and 6 come out.
        new_entry("cycle", 7, 1, 3);
        append_edge(0, 1);
        append_edge(1, 2);
        append_edge(2, 3);
        append_edge(3, 4);
        append_edge(4, 2);
        append_edge(4, 5);
        append_edge(0, 6);
        // Leftover indegrees from the cycle would stall this chain.
        new_entry("reuse_after_cycle", 6, 0, 6);
        append_edge(3, 1);
        append_edge(1, 4);
        append_edge(4, 0);
        append_edge(0, 5);
        append_edge(5, 2);
        append_order(3);
        append_order(1);
        append_order(4);
        append_order(0);
        append_order(5);
        append_order(2);
        new_entry("single_node", 1, 0, 1);
        append_order(0);
        new_entry("full_size", 16, 0, 16);
        for (v = 0; v < 15; v++) append_edge(v, v + 1);
        for (v = 0; v < 14; v++) append_edge(v, v + 2);
        append_edge(0, 5);
        append_edge(3, 9);
        append_edge(7, 15);
    endtask

    // Outputs are sampled on the falling edge.
    task automatic collect_output();
        logic finished;
        got.delete();
        last_idx = -1;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            if (sort_stb) begin
                if (sort_out.last && last_idx < 0) last_idx = got.size();  // First flag only.
                got.push_back(int'(sort_out.node));
            end
            if (done) begin
                cyc_flag = int'(cycle_found);
                finished = 1'b1;
            end
        end
    endtask

    task automatic check_result(input int t);
        int          pos [max_nodes];
        int          seen[max_nodes];
        int          k;
        int          v;
        graph_edge_t ge;
        check("cycle_found", t_cycle[t], cyc_flag);
        check("nodes emitted", t_count[t], got.size());
        for (v = 0; v < max_nodes; v++) begin
            pos[v]  = -1;
            seen[v] = 0;
        end
        for (k = 0; k < got.size(); k++) begin
            check($sformatf("node %0d below node count", got[k]), 1, int'(got[k] < t_nodes[t]));
            seen[got[k]]++;
            pos[got[k]] = k;
        end
        for (v = 0; v < t_nodes[t]; v++) begin
            if (t_cycle[t] == 0) begin
                check($sformatf("times node %0d emitted", v), 1, seen[v]);
            end else begin
                check($sformatf("node %0d repeated", v), 0, int'(seen[v] > 1));
            end
        end
        // A node may come out only after every source of its incoming edges.
        for (k = 0; k < t_e_num[t]; k++) begin
            ge = edge_pool[t_e_first[t] + k];
            if (pos[ge.dst] >= 0) begin
                check($sformatf("edge %0d->%0d in order", ge.src, ge.dst), 1,
                      int'(pos[ge.src] >= 0 && pos[ge.src] < pos[ge.dst]));
            end
        end
        if (t_o_first[t] >= 0) begin
            for (k = 0; k < t_count[t] && k < got.size(); k++) begin
                check($sformatf("node at position %0d", k), order_pool[t_o_first[t] + k], got[k]);
            end
        end
        if (t_cycle[t] == 0) begin
            check("position of last flag", t_count[t] - 1, last_idx);
        end
    endtask

    task automatic run_test(input int t);
        int k;
        cur_name    = t_name[t];
        test_errors = 0;
        for (k = 0; k < t_e_num[t]; k++) begin
            edge_stb = 1'b1;
            edge_in  = edge_pool[t_e_first[t] + k];
            @(posedge clk);
            #2;
        end
        edge_stb   = 1'b0;
        load_done  = 1'b1;
        node_count = cnt_t'(t_nodes[t]);
        @(posedge clk);
        #2;
        load_done = 1'b0;
        collect_output();
        check_result(t);
        if (test_errors == 0) begin
            $display("test %s: ok, %0d of %0d nodes out", cur_name, got.size(), t_nodes[t]);
        end else begin
            $display("test %s: %0d mismatches", cur_name, test_errors);
            tests_failed++;
        end
        @(posedge clk);  // Storage clears on this edge.
        #2;
    endtask

    initial begin
        int t;
        int sum;
        void'($urandom(88800));
        arst_n       = 1'b0;
        edge_stb     = 1'b0;
        edge_in      = '0;
        load_done    = 1'b0;
        node_count   = '0;
        errors       = 0;
        tests_failed = 0;
        n_built      = 0;
        edge_fill    = 0;
        order_fill   = 0;
        cycle_limit  = 0;
        build_table();
        sum = 0;
        for (t = 0; t < num_tests; t++) sum += t_nodes[t] + t_e_num[t];
        cycle_limit = 20 + 10 * sum;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (t = 0; t < num_tests; t++) run_test(t);
        $display("%0d tests run, %0d passed, %0d failed, %0d mismatches",
                 num_tests, num_tests - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* src/graph_topo_top.sv */
`timescale 1ns/1ps

module graph_topo_top import topo_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        edge_stb,
    input  graph_edge_t edge_in,
    input  logic        load_done,
    input  cnt_t        node_count,
    output logic        sort_stb,
    output sorted_t     sort_out,
    output logic        done,
    output logic        cycle_found
);

    node_t      indeg_node;
    logic       indeg_dec;
    cnt_t       indeg_degree;
    logic       query_valid;
    logic       query_ready;
    node_t      query_node;
    logic       reply_valid;
    logic       reply_ready;
    adj_reply_t reply;

    // The done pulse wipes both storage blocks for the next graph.
    indegree_table indegree_table_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .clear        (done),
        .edge_stb     (edge_stb),
        .edge_in      (edge_in),
        .indeg_node   (indeg_node),
        .indeg_dec    (indeg_dec),
        .indeg_degree (indeg_degree)
    );

    adjacency_map adjacency_map_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear       (done),
        .edge_stb    (edge_stb),
        .edge_in     (edge_in),
        .query_valid (query_valid),
        .query_node  (query_node),
        .reply_ready (reply_ready),
        .query_ready (query_ready),
        .reply_valid (reply_valid),
        .reply       (reply)
    );

    kahn_sorter kahn_sorter_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_done    (load_done),
        .node_count   (node_count),
        .indeg_degree (indeg_degree),
        .query_ready  (query_ready),
        .reply_valid  (reply_valid),
        .reply        (reply),
        .indeg_node   (indeg_node),
        .indeg_dec    (indeg_dec),
        .query_valid  (query_valid),
        .query_node   (query_node),
        .reply_ready  (reply_ready),
        .sort_stb     (sort_stb),
        .sort_out     (sort_out),
        .done         (done),
        .cycle_found  (cycle_found)
    );

    // Edges are only taken while the sorter is idle, an edge during a sort
    // would corrupt the tables it is walking.
    edge_while_sorting: assert property (
        @(posedge clk) disable iff (!arst_n)
        edge_stb |-> (kahn_sorter_i.state == st_idle)
    ) else $error("edge loaded while a sort is running");

endmodule

/* sorter/kahn_sorter.sv */
`timescale 1ns/1ps

module kahn_sorter import topo_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       load_done,
    input  cnt_t       node_count,
    input  cnt_t       indeg_degree,
    input  logic       query_ready,
    input  logic       reply_valid,
    input  adj_reply_t reply,
    output node_t      indeg_node,
    output logic       indeg_dec,
    output logic       query_valid,
    output node_t      query_node,
    output logic       reply_ready,
    output logic       sort_stb,
    output sorted_t    sort_out,
    output logic       done,
    output logic       cycle_found
);

    sort_state_t state;
    sort_state_t state_nxt;

    cnt_t n_cnt;         // Node count latched at load_done.
    cnt_t emitted;
    logic reply_last_q;  // The reply being processed closes its list.

    // Queue of nodes whose indegree has reached zero.
    node_t fifo_mem [max_nodes];
    node_t wr_ptr;
    node_t rd_ptr;
    cnt_t  fifo_cnt;
    logic  fifo_empty;
    logic  push;
    logic  pop;
    logic  sweep_end;

    assign fifo_empty = (fifo_cnt == '0);
    assign sweep_end  = ({1'b0, indeg_node} + 1'b1) >= n_cnt;

    always_comb begin
        state_nxt = state;
        unique case (state)
            st_idle: begin
                if (load_done) begin
                    state_nxt = st_sweep;
                end
            end
            st_sweep: begin
                if (sweep_end) begin
                    state_nxt = st_pop;
                end
            end
            st_pop: begin
                state_nxt = fifo_empty ? st_done : st_query;
            end
            st_query: begin
                if (query_ready) begin
                    state_nxt = st_wait_reply;
                end
            end
            st_wait_reply: begin
                if (reply_valid) begin
                    state_nxt = reply.empty ? st_pop : st_dec;  // Nothing to decrement.
                end
            end
            st_dec:   state_nxt = st_check;
            st_check: state_nxt = reply_last_q ? st_pop : st_wait_reply;
            st_done:  state_nxt = st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    assign query_valid = (state == st_query);
    assign query_node  = sort_out.node;
    assign reply_ready = (state == st_wait_reply);
    assign indeg_dec   = (state == st_dec);

    // Both push sources take the node on the indegree address. In the sweep
    // that is the scan index, in st_check it is the destination just decremented.
    assign push = ((state == st_sweep) && ({1'b0, indeg_node} < n_cnt)
                   && (indeg_degree == '0))
               || ((state == st_check) && (indeg_degree == '0));
    assign pop  = (state == st_pop) && !fifo_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= st_idle;
            n_cnt        <= '0;
            emitted      <= '0;
            reply_last_q <= 1'b0;
            indeg_node   <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_cnt     <= '0;
            sort_stb     <= 1'b0;
            done         <= 1'b0;
            cycle_found  <= 1'b0;
        end else begin
            state    <= state_nxt;
            sort_stb <= pop;
            done     <= (state == st_pop) && fifo_empty;

            // Fewer nodes out than declared means some indegrees never reached zero.
            cycle_found <= (state == st_pop) && fifo_empty && (emitted < n_cnt);

            if ((state == st_idle) && load_done) begin
                n_cnt      <= node_count;
                emitted    <= '0;
                indeg_node <= '0;
                wr_ptr     <= '0;
                rd_ptr     <= '0;
                fifo_cnt   <= '0;
            end
            if (state == st_sweep) begin
                indeg_node <= indeg_node + 1'b1;
            end
            if (reply_valid && reply_ready) begin
                reply_last_q <= reply.last;
                if (!reply.empty) begin
                    indeg_node <= reply.dst;
                end
            end
            if (push) begin
                wr_ptr   <= wr_ptr + 1'b1;
                fifo_cnt <= fifo_cnt + 1'b1;
            end
            if (pop) begin
                rd_ptr   <= rd_ptr + 1'b1;
                fifo_cnt <= fifo_cnt - 1'b1;
                emitted  <= emitted + 1'b1;
            end
        end
    end

    // Pushes and pops never share a cycle.
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= indeg_node;
        end
        if (pop) begin
            sort_out.node <= fifo_mem[rd_ptr];
            // Once every declared node is out, no reply can refill the queue.
            sort_out.last <= (fifo_cnt == cnt_t'(1)) && ((emitted + 1'b1) == n_cnt);
        end
    end

    // Each node is queued at most once, so the queue never overflows.
    fifo_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> (fifo_cnt < max_nodes)
    ) else $error("zero-indegree queue overflow");

endmodule

/* adjacency_map/adjacency_map.sv */
`timescale 1ns/1ps

module adjacency_map import topo_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clear,
    input  logic        edge_stb,
    input  graph_edge_t edge_in,
    input  logic        query_valid,
    input  node_t       query_node,
    input  logic        reply_ready,
    output logic        query_ready,
    output logic        reply_valid,
    output adj_reply_t  reply
);

    // List heads, one per source node.
    edge_ptr_t            head [max_nodes];
    logic [max_nodes-1:0] head_vld;

    // Edge slots. Each holds a destination and a link to the next slot.
    node_t                slot_dst  [max_edges];
    edge_ptr_t            slot_next [max_edges];
    logic [max_edges-1:0] slot_has_next;

    logic [edge_w:0] wr_cnt;  // Counts up to max_edges inclusive.
    edge_ptr_t       wr_slot;

    logic      walking;
    logic      walk_empty;
    edge_ptr_t cur;
    logic      query_acc;
    logic      reply_acc;

    assign wr_slot     = wr_cnt[edge_w-1:0];
    assign query_ready = !walking;
    assign query_acc   = query_valid && query_ready;
    assign reply_valid = walking;
    assign reply_acc   = reply_valid && reply_ready;

    always_comb begin
        reply.dst   = slot_dst[cur];
        reply.empty = walk_empty;
        reply.last  = walk_empty || !slot_has_next[cur];
    end

    // A new edge goes in front of its source's current head, so the list
    // is read back newest first.
    always_ff @(posedge clk) begin
        if (edge_stb) begin
            slot_dst[wr_slot]      <= edge_in.dst;
            slot_next[wr_slot]     <= head[edge_in.src];
            slot_has_next[wr_slot] <= head_vld[edge_in.src];
            head[edge_in.src]      <= wr_slot;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_vld   <= '0;
            wr_cnt     <= '0;
            walking    <= 1'b0;
            walk_empty <= 1'b0;
            cur        <= '0;
        end else if (clear) begin
            // Slot contents stay, they are unreachable once the heads are gone.
            head_vld <= '0;
            wr_cnt   <= '0;
            walking  <= 1'b0;
        end else begin
            if (edge_stb) begin
                head_vld[edge_in.src] <= 1'b1;
                wr_cnt                <= wr_cnt + 1'b1;
            end
            if (query_acc) begin
                walking    <= 1'b1;
                walk_empty <= !head_vld[query_node];  // Still one reply, flagged empty.
                cur        <= head[query_node];
            end else if (reply_acc) begin
                if (reply.last) begin
                    walking <= 1'b0;
                end else begin
                    cur <= slot_next[cur];
                end
            end
        end
    end

    // Slot storage wraps silently past max_edges and would corrupt older lists.
    edge_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        edge_stb |-> (wr_cnt < max_edges)
    ) else $error("more than %0d edges loaded", max_edges);

    // A walk in progress must run to its last entry before the map is cleared.
    clear_mid_walk: assert property (
        @(posedge clk) disable iff (!arst_n)
        clear |-> !walking
    ) else $error("adjacency map cleared during a list walk");

endmodule

/* src/indegree_table.sv */
`timescale 1ns/1ps

module indegree_table import topo_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clear,
    input  logic        edge_stb,
    input  graph_edge_t edge_in,
    input  node_t       indeg_node,
    input  logic        indeg_dec,
    output cnt_t        indeg_degree
);

    cnt_t counts [max_nodes];

    // The sorter samples this in the same cycle it presents the address.
    assign indeg_degree = counts[indeg_node];

    // Edge loading and the sort never overlap, so the increment and the
    // decrement do not collide on one entry.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            counts <= '{default: '0};
        end else if (clear) begin
            counts <= '{default: '0};  // Ready for the next graph.
        end else begin
            if (edge_stb) begin
                counts[edge_in.dst] <= counts[edge_in.dst] + 1'b1;
            end
            if (indeg_dec) begin
                counts[indeg_node] <= counts[indeg_node] - 1'b1;
            end
        end
    end

    // Every decrement must match an edge that was counted during loading.
    dec_of_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        indeg_dec |-> (counts[indeg_node] != '0)
    ) else $error("indegree of node %0d decremented below zero", indeg_node);

endmodule

/* common/topo_pkg.sv */
package topo_pkg;

    // Graph size limits. The whole design is built for this one size.
    localparam int max_nodes = 16;
    localparam int max_edges = 32;
    localparam int node_w    = 4;
    localparam int edge_w    = 5;

    typedef logic [node_w-1:0] node_t;
    typedef logic [edge_w-1:0] edge_ptr_t;

    // One bit wider than a node index so that a full count of 16 fits.
    typedef logic [node_w:0] cnt_t;

    // One directed edge as loaded by the host.
    typedef struct packed {
        node_t src;
        node_t dst;
    } graph_edge_t;

    // One entry of an adjacency list walk.
    typedef struct packed {
        node_t dst;
        logic  last;   // Final entry of the list.
        logic  empty;  // The list had no entries, dst carries nothing.
    } adj_reply_t;

    // One item of the sorted output stream.
    typedef struct packed {
        node_t node;
        logic  last;
    } sorted_t;

    typedef enum logic [2:0] {
        st_idle,
        st_sweep,
        st_pop,
        st_query,
        st_wait_reply,
        st_dec,
        st_check,
        st_done
    } sort_state_t;

endpackage
